//--- logic/zxmem_config.svh
`ifndef ZXMEM_CONFIG_SVH
`define ZXMEM_CONFIG_SVH

// --------------------------------------------------
// ZX-UNO register numbers
// --------------------------------------------------
`define ZXMEM_MASTERCONF           8'h00
`define ZXMEM_MASTERMAPPER         8'h01

// DivMMC control port, low byte only
`define ZXMEM_DIVMMC_PORT          8'hE3

// --------------------------------------------------
// Automapper entry and exit points
// --------------------------------------------------
`define ZXMEM_ENTRY_0000           16'h0000   // Reset
`define ZXMEM_ENTRY_0008           16'h0008   // RST 8, error handler
`define ZXMEM_ENTRY_0038           16'h0038   // Maskable interrupt
`define ZXMEM_ENTRY_0066           16'h0066   // NMI
`define ZXMEM_ENTRY_04C6           16'h04C6   // Tape save
`define ZXMEM_ENTRY_0562           16'h0562   // Tape load
`define ZXMEM_ENTRY_3D_PAGE        8'h3D      // Immediate entry, TR-DOS style
`define ZXMEM_EXIT_PREFIX          13'h03FF   // 1FF8 to 1FFF

// SRAM layout
`define ZXMEM_SRAM_AW              19
`define ZXMEM_DIVMMC_ROM_PAGE      6'b011000  // DivMMC EEPROM image
`define ZXMEM_DIVMMC_MAPRAM_PAGE   6'b100011  // DivMMC RAM page 3
`define ZXMEM_ROM_BASE             3'b010     // Four 16K ROMs from SRAM page 8

`endif

//--- logic/zxmem_pkg.sv
`include "zxmem_config.svh"

package zxmem_pkg;

   // ZX-UNO register numbers on the addr bus
   typedef enum logic [7:0] {
      MASTERCONF   = `ZXMEM_MASTERCONF,
      MASTERMAPPER = `ZXMEM_MASTERMAPPER
   } zxuno_reg_e;

   // +3 all-RAM layouts, pages from 0000 up to C000
   typedef enum logic [1:0] {
      ARR_0123 = 2'd0,
      ARR_4567 = 2'd1,
      ARR_4563 = 2'd2,
      ARR_4763 = 2'd3
   } plus3_arrangement_e;

   // Quarter of the CPU address space, a[15:14]
   typedef enum logic [1:0] {
      REGION_ROM  = 2'd0,
      REGION_4000 = 2'd1,
      REGION_8000 = 2'd2,
      REGION_C000 = 2'd3
   } cpu_region_e;

endpackage

//--- logic/master_config.sv
`timescale 1ns/1ps

module master_config (
   input  logic       clk,
   input  logic       mrst_n,                 // Master reset only
   input  logic [7:0] addr,                   // ZX-UNO register number
   input  logic       iow,
   input  logic [7:0] din,
   input  logic       page_configrom_active,
   output logic       initial_boot_mode,
   output logic       masterconf_frozen,
   output logic       divmmc_is_enabled,
   output logic       divmmc_nmi_disabled,
   output logic [1:0] timing_mode,
   output logic       disable_contention,
   output logic       issue2_keyboard_enabled,
   output logic [4:0] mastermapper            // 16K SRAM page at C000 in boot mode
);

   logic [1:0] cfg_sampler;                   // Two-stage sampler of the config ROM flag

   // --------------------------------------------------
   // MASTERCONF
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         cfg_sampler <= 2'b00;
         {timing_mode[1], disable_contention, timing_mode[0], issue2_keyboard_enabled,
          divmmc_nmi_disabled, divmmc_is_enabled, initial_boot_mode} <= 7'b0000001;
         masterconf_frozen <= 1'b0;
      end else begin
         cfg_sampler <= {cfg_sampler[0], page_configrom_active};
         if (page_configrom_active) begin       // Config ROM running, back to boot
            masterconf_frozen <= 1'b0;
            initial_boot_mode <= 1'b1;
         end else if (cfg_sampler == 2'b10) begin  // Config ROM just released
            masterconf_frozen <= 1'b1;
            initial_boot_mode <= 1'b0;
         end else if (iow && addr == zxmem_pkg::MASTERCONF) begin
            // Option bits stay writable after the freeze
            {timing_mode[1], disable_contention, timing_mode[0],
             issue2_keyboard_enabled} <= din[6:3];
            if (!masterconf_frozen) begin
               masterconf_frozen <= din[7];
               {divmmc_nmi_disabled, divmmc_is_enabled, initial_boot_mode} <= din[2:0];
            end
         end
      end
   end

   // MASTERMAPPER, boot mode only
   always_ff @(posedge clk) begin
      if (!mrst_n)
         mastermapper <= 5'h00;
      else if (iow && initial_boot_mode && addr == zxmem_pkg::MASTERMAPPER)
         mastermapper <= din[4:0];
   end

endmodule

//--- logic/divmmc_automapper.sv
`timescale 1ns/1ps
`include "zxmem_config.svh"

module divmmc_automapper (
   input  logic        clk,
   input  logic        mrst_n,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic [7:0]  din,
   input  logic        mreq_n,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic        m1_n,
   input  logic        divmmc_nmi_disabled,
   input  logic        page_configrom_active,
   output logic        divmmc_paged,
   output logic        conmem,              // Forced mapping, bit 7
   output logic        mapram_mode,         // RAM page 3 as ROM, bit 6
   output logic [3:0]  divmmc_sram_page     // Upper 8K page, bits 3..0
);

   logic m1_read;                           // Opcode fetch in progress
   logic entry_deferred;
   logic pending;                           // Paging state once M1 ends

   assign m1_read = !mreq_n && !rd_n && !m1_n;

   always_comb begin
      entry_deferred = a == `ZXMEM_ENTRY_0000 || a == `ZXMEM_ENTRY_0008 ||
                       a == `ZXMEM_ENTRY_0038 || a == `ZXMEM_ENTRY_04C6 ||
                       a == `ZXMEM_ENTRY_0562 ||
                       (a == `ZXMEM_ENTRY_0066 && !divmmc_nmi_disabled &&
                        !page_configrom_active);  // NMI entry gated
   end

   // --------------------------------------------------
   // Control port E3
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         {conmem, mapram_mode, divmmc_sram_page} <= 6'b000000;
      end else if (!iorq_n && !wr_n && a[7:0] == `ZXMEM_DIVMMC_PORT) begin
         conmem           <= din[7];
         mapram_mode      <= din[6];
         divmmc_sram_page <= din[3:0];
      end
   end

   // Automapper
   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         divmmc_paged <= 1'b0;
         pending      <= 1'b0;
      end else begin
         if (m1_read && entry_deferred) begin
            pending <= 1'b1;                   // Maps after this fetch
         end else if (m1_read && a[15:8] == `ZXMEM_ENTRY_3D_PAGE) begin
            divmmc_paged <= 1'b1;              // Maps during this fetch
            pending      <= 1'b1;
         end else if (m1_read && a[15:3] == `ZXMEM_EXIT_PREFIX) begin
            pending <= 1'b0;                   // Unmaps after this fetch
         end
         if (m1_n)
            divmmc_paged <= pending;           // M1 over, apply
      end
   end

endmodule

//--- logic/spectrum_pager.sv
`timescale 1ns/1ps

module spectrum_pager (
   input  logic        clk,
   input  logic        mrst_n,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic [7:0]  din,
   input  logic        iorq_n,
   input  logic        wr_n,
   input  logic        disable_7ffd,
   input  logic        disable_1ffd,
   input  logic        disable_romsel7f,
   input  logic        disable_romsel1f,
   output logic [2:0]  ram_bank,               // Bank at C000
   output logic [1:0]  rom_bank,
   output logic        vram_select,            // Shadow screen, bank 7
   output logic        allram_mode,
   output zxmem_pkg::plus3_arrangement_e arrangement
);

   logic [5:0] bank128;                        // 7FFD, lock in bit 5
   logic [2:0] bankplus3;                      // 1FFD, low bits only
   logic       io_write;
   logic       sel_1ffd;
   logic       sel_7ffd;

   assign io_write = !iorq_n && !wr_n;
   assign sel_1ffd = a[0] && !a[1] && a[12] && a[15:13] == 3'b000;
   // +2A form needs a[14], plain 128K form ignores it
   assign sel_7ffd = a[0] && !a[1] && !a[15] && (a[14] || disable_1ffd);

   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         bank128   <= 6'b000000;
         bankplus3 <= 3'b000;
      end else if (io_write && !bank128[5]) begin   // Lock freezes both ports
         if (!disable_1ffd && sel_1ffd)
            bankplus3 <= din[2:0];
         else if (!disable_7ffd && sel_7ffd)
            bank128 <= din[5:0];
      end
   end

   assign ram_bank    = bank128[2:0];
   assign vram_select = bank128[3];
   assign rom_bank    = {bankplus3[2] & ~disable_romsel1f, bank128[4] & ~disable_romsel7f};
   assign allram_mode = bankplus3[0];
   assign arrangement = zxmem_pkg::plus3_arrangement_e'(bankplus3[2:1]);

endmodule

//--- logic/sram_address_map.sv
`timescale 1ns/1ps
`include "zxmem_config.svh"

module sram_address_map (
   input  logic [15:0] a,
   input  logic        mreq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   input  logic        initial_boot_mode,
   input  logic        inhibit_rom,          // External ROMCS
   input  logic [4:0]  mastermapper,
   input  logic        divmmc_is_enabled,
   input  logic        divmmc_paged,
   input  logic        conmem,
   input  logic        mapram_mode,
   input  logic [3:0]  divmmc_sram_page,
   input  logic [2:0]  ram_bank,
   input  logic [1:0]  rom_bank,
   input  logic        allram_mode,
   input  zxmem_pkg::plus3_arrangement_e arrangement,
   output logic [`ZXMEM_SRAM_AW-1:0] sram_addr,
   output logic        sram_we_n,
   output logic [7:0]  sram_wdata,
   output logic        ram_oe_n,
   output logic        bootrom_cs,
   output logic        access_to_screen
);

   zxmem_pkg::cpu_region_e region;

   // 16K RAM page in the low 128K
   function automatic logic [`ZXMEM_SRAM_AW-1:0] ram_page(input logic [2:0] page,
                                                          input logic [13:0] offset);
      ram_page = {2'b00, page, offset};
   endfunction

   assign region     = zxmem_pkg::cpu_region_e'(a[15:14]);
   assign sram_wdata = din;

   always_comb begin
      ram_oe_n   = mreq_n | rd_n;
      sram_we_n  = mreq_n | wr_n;
      bootrom_cs = 1'b0;
      sram_addr  = '0;
      case (region)
         // --------------------------------------------------
         zxmem_pkg::REGION_ROM: begin
            if (initial_boot_mode) begin       // Internal boot ROM only
               ram_oe_n   = 1'b1;
               sram_we_n  = 1'b1;
               bootrom_cs = !mreq_n;
            end else if (inhibit_rom) begin    // External ROM owns the bus
               ram_oe_n  = 1'b1;
               sram_we_n = 1'b1;
            end else if (divmmc_is_enabled && (divmmc_paged || conmem)) begin
               if (!a[13]) begin               // Lower 8K, EEPROM or RAM page 3
                  sram_addr = (conmem || !mapram_mode) ?
                              {`ZXMEM_DIVMMC_ROM_PAGE, a[12:0]} :
                              {`ZXMEM_DIVMMC_MAPRAM_PAGE, a[12:0]};
                  sram_we_n = 1'b1;
               end else begin                  // Upper 8K, selected RAM page
                  sram_addr = {2'b10, divmmc_sram_page, a[12:0]};
                  if (!conmem && mapram_mode && divmmc_sram_page == 4'd3)
                     sram_we_n = 1'b1;         // Page 3 acts as ROM here
               end
            end else if (!allram_mode) begin
               sram_addr = {`ZXMEM_ROM_BASE, rom_bank, a[13:0]};
               sram_we_n = 1'b1;
            end else begin
               sram_addr = ram_page((arrangement == zxmem_pkg::ARR_0123) ? 3'd0 : 3'd4,
                                    a[13:0]);
            end
         end
         // --------------------------------------------------
         zxmem_pkg::REGION_4000: begin
            if (initial_boot_mode || !allram_mode)
               sram_addr = ram_page(3'd5, a[13:0]);
            else
               case (arrangement)
                  zxmem_pkg::ARR_0123: sram_addr = ram_page(3'd1, a[13:0]);
                  zxmem_pkg::ARR_4763: sram_addr = ram_page(3'd7, a[13:0]);
                  default:             sram_addr = ram_page(3'd5, a[13:0]);
               endcase
         end
         zxmem_pkg::REGION_8000: begin
            if (initial_boot_mode || !allram_mode || arrangement == zxmem_pkg::ARR_0123)
               sram_addr = ram_page(3'd2, a[13:0]);
            else
               sram_addr = ram_page(3'd6, a[13:0]);
         end
         default: begin                        // C000
            if (initial_boot_mode)
               sram_addr = {mastermapper, a[13:0]};   // Any 16K page of the SRAM
            else if (!allram_mode)
               sram_addr = ram_page(ram_bank, a[13:0]);
            else if (arrangement == zxmem_pkg::ARR_4567)
               sram_addr = ram_page(3'd7, a[13:0]);
            else
               sram_addr = ram_page(3'd3, a[13:0]);
         end
      endcase
   end

   // Contention on the screen banks 5 and 7
   assign access_to_screen = !initial_boot_mode && !allram_mode &&
                             (region == zxmem_pkg::REGION_4000 ||
                              (region == zxmem_pkg::REGION_C000 &&
                               (ram_bank == 3'd5 || ram_bank == 3'd7)));

endmodule

//--- logic/memory_manager.sv
`timescale 1ns/1ps
`include "zxmem_config.svh"

module memory_manager (
   input  logic        clk,
   input  logic        mrst_n,
   input  logic        rst_n,
   // CPU bus
   input  logic [15:0] a,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   output logic        oe_n,                 // dout is valid
   input  logic        mreq_n,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic        m1_n,
   output logic        enable_nmi_n,
   input  logic        page_configrom_active,
   // ULA side
   output logic        issue2_keyboard_enabled,
   output logic [1:0]  timing_mode,
   output logic        disable_contention,
   output logic        access_to_screen,
   // Expansion bus and boot ROM
   input  logic        inhibit_rom,
   input  logic [7:0]  din_external,
   output logic        bootrom_cs,
   input  logic [7:0]  bootrom_data,
   // ZX-UNO registers
   input  logic [7:0]  addr,
   input  logic        ior,
   input  logic        iow,
   output logic        in_boot_mode,
   // Option disables
   input  logic        disable_7ffd,
   input  logic        disable_1ffd,
   input  logic        disable_romsel7f,
   input  logic        disable_romsel1f,
   // SRAM
   output logic [`ZXMEM_SRAM_AW-1:0] sram_addr,
   output logic [7:0]  sram_wdata,
   output logic        sram_we_n,
   input  logic [7:0]  sram_rdata
);

   logic       initial_boot_mode, masterconf_frozen;
   logic       divmmc_is_enabled, divmmc_nmi_disabled;
   logic [4:0] mastermapper;
   logic       divmmc_paged, conmem, mapram_mode;
   logic [3:0] divmmc_sram_page;
   logic [2:0] ram_bank;
   logic [1:0] rom_bank;
   logic       allram_mode;
   logic       ram_oe_n;
   zxmem_pkg::plus3_arrangement_e arrangement;

   assign in_boot_mode = ~masterconf_frozen;
   assign enable_nmi_n = divmmc_is_enabled & divmmc_paged & ~divmmc_nmi_disabled;

   master_config u_master_config (.*);

   divmmc_automapper u_divmmc_automapper (.*);

   spectrum_pager u_spectrum_pager (
      .clk, .mrst_n, .rst_n, .a, .din, .iorq_n, .wr_n,
      .disable_7ffd, .disable_1ffd, .disable_romsel7f, .disable_romsel1f,
      .ram_bank, .rom_bank,
      .vram_select (),                        // No video mirror in this build
      .allram_mode, .arrangement
   );

   sram_address_map u_sram_address_map (.*);

   // --------------------------------------------------
   // CPU read data, highest priority first
   // --------------------------------------------------
   always_comb begin
      oe_n = 1'b0;
      if (bootrom_cs)
         dout = bootrom_data;
      else if (!initial_boot_mode && inhibit_rom && !mreq_n && !rd_n && a[15:14] == 2'b00)
         dout = din_external;                 // ROMCS from the expansion bus
      else if (!ram_oe_n)
         dout = sram_rdata;
      else if (ior && addr == zxmem_pkg::MASTERCONF)
         dout = {masterconf_frozen, timing_mode[1], disable_contention, timing_mode[0],
                 issue2_keyboard_enabled, divmmc_nmi_disabled, divmmc_is_enabled,
                 initial_boot_mode};
      else if (ior && addr == zxmem_pkg::MASTERMAPPER)
         dout = {3'b000, mastermapper};
      else begin
         dout = 8'hFF;                        // Idle bus
         oe_n = 1'b1;
      end
   end

endmodule

//--- verification/memory_manager_properties.sv
`timescale 1ns/1ps

module memory_manager_properties (
   input logic clk,
   input logic mrst_n,
   input logic mreq_n,
   input logic wr_n,
   input logic ior,
   input logic sram_we_n,
   input logic bootrom_cs,
   input logic in_boot_mode,
   input logic oe_n
);

   int fail_count = 0;                          // Failures so far

   // SRAM write strobe only inside a CPU memory write
   we_needs_write: assert property (@(posedge clk) disable iff (!mrst_n)
                                    !sram_we_n |-> (!mreq_n && !wr_n))
   else begin
      $error("sram_we_n low outside a CPU memory write");
      fail_count++;
   end

   // Boot ROM select
   bootrom_in_boot: assert property (@(posedge clk) disable iff (!mrst_n)
                                     bootrom_cs |-> in_boot_mode)
   else begin
      $error("bootrom_cs high outside boot mode");
      fail_count++;
   end

   // Idle bus drives nothing
   idle_no_output: assert property (@(posedge clk) disable iff (!mrst_n)
                                    (mreq_n && !ior) |-> oe_n)
   else begin
      $error("oe_n low with no memory request and no register read");
      fail_count++;
   end

endmodule

//--- verification/memory_manager_tb.sv
`timescale 1ns/1ps

module memory_manager_tb;

   typedef enum logic [2:0] {
      IO_WRITE, REG_WRITE, MEM_READ, MEM_WRITE, M1_FETCH, REG_READ, SOFT_RESET
   } row_kind_e;

   localparam logic [7:0] BOOT_BYTE = 8'hC9;   // Boot ROM answer, never a fill value at 0

   logic        clk = 1'b0;
   logic        mrst_n, rst_n;
   logic [15:0] a;
   logic [7:0]  din, addr, din_external, bootrom_data;
   logic        mreq_n, iorq_n, rd_n, wr_n, m1_n, ior, iow;
   logic        page_configrom_active, inhibit_rom;
   logic        disable_7ffd, disable_1ffd, disable_romsel7f, disable_romsel1f;
   logic [7:0]  dout, sram_wdata, sram_rdata;
   logic        oe_n, enable_nmi_n, issue2_keyboard_enabled, disable_contention;
   logic        access_to_screen, bootrom_cs, in_boot_mode, sram_we_n;
   logic [1:0]  timing_mode;
   logic [18:0] sram_addr;

   // Stimulus table, one entry per row in every queue
   row_kind_e   kind_t [$];
   logic [15:0] a_t [$];                        // CPU address, or register number
   logic [7:0]  data_t [$];
   logic [18:0] addr_t [$];                     // Expected sram_addr
   logic        we_n_t [$];
   logic [7:0]  dout_t [$];
   logic        scr_t [$];
   logic        nmi_t [$];
   logic [5:0]  stat_t [$];                     // Expected bootrom_cs and status outputs
   string       name_t [$];

   // Expected in_boot_mode, timing_mode, disable_contention, issue2_keyboard_enabled
   logic [4:0]  stat_model = 5'b10000;

   integer seed = 60;
   int     checks = 0;
   int     fails = 0;
   int     test_checks = 0;
   int     test_fails = 0;

   always #2 clk = ~clk;                        // 4 ns period

   memory_manager u_dut (.*);

   bind memory_manager memory_manager_properties u_properties (
      .clk, .mrst_n, .mreq_n, .wr_n, .ior, .sram_we_n, .bootrom_cs, .in_boot_mode, .oe_n
   );

   // SRAM model, every address bit takes part
   function automatic logic [7:0] sram_fill(input logic [18:0] loc);
      return loc[7:0] ^ loc[15:8] ^ {5'b10100, loc[18:16]};
   endfunction

   assign sram_rdata = sram_fill(sram_addr);

   // +3 all-RAM page per arrangement and quarter
   function automatic logic [2:0] allram_page(input logic [1:0] arr, input logic [1:0] region);
      case (region)
         2'd0:    return (arr == 2'd0) ? 3'd0 : 3'd4;
         2'd1:    return (arr == 2'd0) ? 3'd1 : ((arr == 2'd3) ? 3'd7 : 3'd5);
         2'd2:    return (arr == 2'd0) ? 3'd2 : 3'd6;
         default: return (arr == 2'd1) ? 3'd7 : 3'd3;
      endcase
   endfunction

   // --------------------------------------------------
   // Table building
   // --------------------------------------------------
   task automatic push_row(input row_kind_e kind, input logic [15:0] a16,
                           input logic [7:0] data, input logic [18:0] exp_addr,
                           input logic exp_we_n, input logic [7:0] exp_dout,
                           input logic exp_scr, input logic exp_nmi, input string name,
                           input logic exp_cs = 1'b0);
      kind_t.push_back(kind);
      a_t.push_back(a16);
      data_t.push_back(data);
      addr_t.push_back(exp_addr);
      we_n_t.push_back(exp_we_n);
      dout_t.push_back(exp_dout);
      scr_t.push_back(exp_scr);
      nmi_t.push_back(exp_nmi);
      stat_t.push_back({exp_cs, stat_model});
      name_t.push_back(name);
   endtask

   task automatic io_row(input logic [15:0] port, input logic [7:0] data, input string name);
      push_row(IO_WRITE, port, data, '0, 1'b1, 8'hFF, 1'b0, 1'b0, name);
   endtask

   task automatic regwrite_row(input zxmem_pkg::zxuno_reg_e r, input logic [7:0] data,
                               input string name);
      push_row(REG_WRITE, 16'(r), data, '0, 1'b1, 8'hFF, 1'b0, 1'b0, name);
   endtask

   task automatic regread_row(input zxmem_pkg::zxuno_reg_e r, input logic [7:0] exp,
                              input string name);
      push_row(REG_READ, 16'(r), 8'($random(seed)), '0, 1'b1, exp, 1'b0, 1'b0, name);
   endtask

   task automatic read_row(input logic [15:0] a16, input logic [18:0] exp_addr,
                           input logic scr, input logic nmi, input string name);
      push_row(MEM_READ, a16, 8'($random(seed)), exp_addr, 1'b1, sram_fill(exp_addr),
               scr, nmi, name);
   endtask

   task automatic write_row(input logic [15:0] a16, input logic [18:0] exp_addr,
                            input logic we_n, input logic scr, input logic nmi,
                            input string name);
      push_row(MEM_WRITE, a16, 8'($random(seed)), exp_addr, we_n, 8'hFF, scr, nmi, name);
   endtask

   task automatic fetch_row(input logic [15:0] a16, input logic [18:0] exp_addr,
                            input logic nmi, input string name);
      push_row(M1_FETCH, a16, 8'($random(seed)), exp_addr, 1'b1, sram_fill(exp_addr),
               1'b0, nmi, name);
   endtask

   task automatic build_table;
      regread_row(zxmem_pkg::MASTERCONF, 8'h01, "boot_mode");        // Boot bit only
      regwrite_row(zxmem_pkg::MASTERMAPPER, 8'h13, "boot_mode");
      regread_row(zxmem_pkg::MASTERMAPPER, 8'h13, "boot_mode");
      read_row(16'hC123, 19'h4C123, 1'b0, 1'b0, "boot_mode");       // Page 13 at C000
      push_row(MEM_READ, 16'h0005, 8'h00, '0, 1'b1, BOOT_BYTE, 1'b0, 1'b0, "boot_mode",
               1'b1);
      write_row(16'h4000, 19'h14000, 1'b0, 1'b0, 1'b0, "boot_mode");
      regwrite_row(zxmem_pkg::MASTERCONF, 8'h82, "paging_128");      // Freeze, DivMMC on
      stat_model = 5'b00000;
      regread_row(zxmem_pkg::MASTERCONF, 8'h82, "paging_128");
      regwrite_row(zxmem_pkg::MASTERCONF, 8'hF8, "paging_128");      // Low bits now locked
      stat_model = 5'b01111;
      regread_row(zxmem_pkg::MASTERCONF, 8'hFA, "paging_128");
      regwrite_row(zxmem_pkg::MASTERCONF, 8'h82, "paging_128");
      stat_model = 5'b00000;
      io_row(16'h7FFD, 8'h03, "paging_128");
      read_row(16'hC010, 19'h0C010, 1'b0, 1'b0, "paging_128");
      read_row(16'h0100, 19'h20100, 1'b0, 1'b0, "paging_128");      // ROM 0
      io_row(16'h7FFD, 8'h17, "paging_128");
      read_row(16'h0100, 19'h24100, 1'b0, 1'b0, "paging_128");      // ROM 1
      write_row(16'h0200, 19'h24200, 1'b1, 1'b0, 1'b0, "paging_128");
      read_row(16'hC000, 19'h1C000, 1'b1, 1'b0, "paging_128");
      io_row(16'h7FFD, 8'h21, "paging_128");                         // Bank 1 and lock
      io_row(16'h7FFD, 8'h04, "paging_128");
      read_row(16'hC000, 19'h04000, 1'b0, 1'b0, "paging_128");
      read_row(16'h0100, 19'h20100, 1'b0, 1'b0, "paging_128");
      push_row(SOFT_RESET, 16'h0000, 8'h00, '0, 1'b1, 8'hFF, 1'b0, 1'b0, "allram");
      read_row(16'hC000, 19'h00000, 1'b0, 1'b0, "allram");
      for (int arr = 0; arr < 4; arr++) begin
         io_row(16'h1FFD, 8'(arr * 2 + 1), "allram");
         for (int r = 0; r < 4; r++)
            read_row({2'(r), 14'h0123}, {2'b00, allram_page(2'(arr), 2'(r)), 14'h0123},
                     1'b0, 1'b0, "allram");
      end
      write_row(16'h0040, 19'h10040, 1'b0, 1'b0, 1'b0, "allram");   // RAM 4 is writable
      io_row(16'h1FFD, 8'h00, "allram");
      fetch_row(16'h0038, 19'h20038, 1'b0, "divmmc");               // Deferred entry
      read_row(16'h0100, 19'h30100, 1'b0, 1'b1, "divmmc");
      write_row(16'h2005, 19'h40005, 1'b0, 1'b0, 1'b1, "divmmc");
      fetch_row(16'h1FF8, 19'h31FF8, 1'b1, "divmmc");               // Exit range
      read_row(16'h0100, 19'h20100, 1'b0, 1'b0, "divmmc");
      io_row(16'h00E3, 8'h45, "divmmc");                             // Mapram, page 5
      fetch_row(16'h3D05, 19'h23D05, 1'b0, "divmmc");
      read_row(16'h0100, 19'h46100, 1'b0, 1'b1, "divmmc");
      write_row(16'h2000, 19'h4A000, 1'b0, 1'b0, 1'b1, "divmmc");
      fetch_row(16'h1FF8, 19'h47FF8, 1'b1, "divmmc");
      io_row(16'h00E3, 8'h80, "divmmc");                             // Conmem
      read_row(16'h0100, 19'h30100, 1'b0, 1'b0, "divmmc");
      io_row(16'h00E3, 8'h00, "divmmc");
      read_row(16'h4000, 19'h14000, 1'b1, 1'b0, "screen_flag");
      read_row(16'hC000, 19'h00000, 1'b0, 1'b0, "screen_flag");
      io_row(16'h7FFD, 8'h05, "screen_flag");
      read_row(16'hC000, 19'h14000, 1'b1, 1'b0, "screen_flag");
      io_row(16'h7FFD, 8'h07, "screen_flag");
      read_row(16'hC000, 19'h1C000, 1'b1, 1'b0, "screen_flag");
      io_row(16'h1FFD, 8'h01, "screen_flag");
      read_row(16'h4000, 19'h04000, 1'b0, 1'b0, "screen_flag");     // All-RAM, no contention
   endtask

   // --------------------------------------------------
   // Driving and checking
   // --------------------------------------------------
   task automatic drive_idle;
      mreq_n = 1'b1;
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
      m1_n   = 1'b1;
      ior    = 1'b0;
      iow    = 1'b0;
      rst_n  = 1'b1;
   endtask

   task automatic compare_field(input logic [31:0] got, input logic [31:0] exp,
                                input string field, input string test);
      checks++;
      test_checks++;
      assert (got === exp)
      else begin
         $display("Mismatch at %0t: %s %s is %0h, expected %0h", $time, test, field, got, exp);
         fails++;
         test_fails++;
      end
   endtask

   task automatic apply_row(input int i);
      int waited;
      @(posedge clk);
      #1;
      a      = a_t[i];
      din    = data_t[i];
      addr   = a_t[i][7:0];
      iorq_n = (kind_t[i] != IO_WRITE);
      iow    = (kind_t[i] == REG_WRITE);
      ior    = (kind_t[i] == REG_READ);
      mreq_n = !(kind_t[i] inside {MEM_READ, MEM_WRITE, M1_FETCH});
      rd_n   = !(kind_t[i] inside {MEM_READ, M1_FETCH});
      wr_n   = !(kind_t[i] inside {MEM_WRITE, IO_WRITE});
      m1_n   = (kind_t[i] != M1_FETCH);
      rst_n  = (kind_t[i] != SOFT_RESET);
      #2;                                       // Settled, next edge 1 ns away
      waited = 0;
      if (kind_t[i] inside {MEM_READ, M1_FETCH, REG_READ}) begin
         while (oe_n && waited < 20) begin
            @(posedge clk);
            #3;
            waited++;
         end
         if (oe_n) begin
            $display("Timeout at %0t: no read data from the DUT in test %s", $time, name_t[i]);
            fails++;
            test_fails++;
         end
      end
      if (kind_t[i] inside {MEM_READ, MEM_WRITE, M1_FETCH, REG_READ}) begin
         compare_field(32'(dout), 32'(dout_t[i]), "dout", name_t[i]);
         compare_field(32'(oe_n), 32'(kind_t[i] == MEM_WRITE), "oe_n", name_t[i]);
         compare_field(32'({bootrom_cs, in_boot_mode, timing_mode, disable_contention,
                            issue2_keyboard_enabled}), 32'(stat_t[i]), "status", name_t[i]);
      end
      if (kind_t[i] inside {MEM_READ, MEM_WRITE, M1_FETCH}) begin
         compare_field(32'(sram_addr), 32'(addr_t[i]), "sram_addr", name_t[i]);
         compare_field(32'(sram_we_n), 32'(we_n_t[i]), "sram_we_n", name_t[i]);
         compare_field(32'(access_to_screen), 32'(scr_t[i]), "access_to_screen", name_t[i]);
         compare_field(32'(enable_nmi_n), 32'(nmi_t[i]), "enable_nmi_n", name_t[i]);
         if (kind_t[i] == MEM_WRITE)
            compare_field(32'(sram_wdata), 32'(data_t[i]), "sram_wdata", name_t[i]);
      end
      @(posedge clk);                           // Strobe taken here
      #1;
      drive_idle();                             // One idle cycle per row
   endtask

   initial begin
      int props_failed;
      a = 16'h0000;
      din = 8'h00;
      addr = 8'hFF;
      din_external = 8'h3C;
      bootrom_data = BOOT_BYTE;
      page_configrom_active = 1'b0;
      inhibit_rom = 1'b0;
      disable_7ffd = 1'b0;
      disable_1ffd = 1'b0;
      disable_romsel7f = 1'b0;
      disable_romsel1f = 1'b0;
      drive_idle();
      mrst_n = 1'b0;
      rst_n = 1'b0;
      build_table();
      for (int c = 0; c < 8; c++)
         @(posedge clk);
      #1;
      mrst_n = 1'b1;
      rst_n = 1'b1;
      for (int i = 0; i < kind_t.size(); i++) begin
         apply_row(i);
         if (i + 1 == kind_t.size() || name_t[i + 1] != name_t[i]) begin
            $display("Test %s: %0d checks, %s", name_t[i], test_checks,
                     (test_fails == 0) ? "ok" : "failed");
            test_checks = 0;
            test_fails = 0;
         end
      end
      props_failed = u_dut.u_properties.fail_count;
      if (props_failed != 0) begin
         $display("Bound assertions failed %0d times", props_failed);
         fails += props_failed;
      end
      $display("Checks: %0d, failures: %0d", checks, fails);
      if (fails == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+logic
logic/zxmem_pkg.sv
logic/master_config.sv
logic/divmmc_automapper.sv
logic/spectrum_pager.sv
logic/sram_address_map.sv
logic/memory_manager.sv
verification/memory_manager_properties.sv
verification/memory_manager_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = memory_manager_tb
FILELIST  = verilog.f
OBJDIR    = obj_dir
RUNFLAGS  = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJDIR)
